// ==== design/posit_accum_pkg.sv ====
/*
 * Posit16 (es = 2) accumulator format constants, raw value layout,
 * vector typedefs and a raw value packing helper
 */
package posit_accum_pkg;

    // Posit operand format
    localparam int POSIT_WIDTH = 16;
    localparam int POSIT_ES = 2;

    // Raw value format used inside the accumulator
    localparam int SCALE_WIDTH = 8;
    localparam int ACC_FRAC_WIDTH = 24;
    localparam int MAX_SCALE = 56;
    localparam int RAW_WIDTH = 1 + SCALE_WIDTH + ACC_FRAC_WIDTH + 2;

    typedef logic [POSIT_WIDTH-1:0] posit_t;
    typedef logic signed [SCALE_WIDTH-1:0] scale_t;
    typedef logic [ACC_FRAC_WIDTH-1:0] acc_frac_t;
    typedef logic [RAW_WIDTH-1:0] raw_value_t;

    // Field positions in raw_value_t, top bit down
    localparam int RAW_SGN_BIT = RAW_WIDTH - 1;
    localparam int RAW_SCALE_LSB = 2 + ACC_FRAC_WIDTH;
    localparam int RAW_FRAC_LSB = 2;
    localparam int RAW_INF_BIT = 1;
    localparam int RAW_ZERO_BIT = 0;

    // Special values carry only their flag bit
    localparam raw_value_t RAW_ZERO_VALUE = raw_value_t'(1) << RAW_ZERO_BIT;
    localparam raw_value_t RAW_INF_VALUE = raw_value_t'(1) << RAW_INF_BIT;

    function automatic raw_value_t make_raw(
        input logic      sgn,
        input scale_t    scale,
        input acc_frac_t frac,
        input logic      inf,
        input logic      zero
    );
        return {sgn, scale, frac, inf, zero};
    endfunction

endpackage

// ==== design/posit_decode.sv ====
/*
 * Posit16 decoder: absolute value, regime run, exponent and fraction
 * extraction into the registered raw value form
 */
`timescale 1ns/1ps

module posit_decode
    import posit_accum_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       clear,
    input  posit_t     operand,
    output logic       dec_valid,
    output logic       dec_clear,
    output raw_value_t dec_value
);

    // Fraction bits left after the regime terminator and exponent
    localparam int FRAC_BITS = POSIT_WIDTH - 1 - POSIT_ES;

    posit_t                  abs_val;
    logic [POSIT_WIDTH-2:0]  body;
    logic [POSIT_WIDTH-2:0]  rem;
    logic [4:0]              run_len;
    logic                    run_end;
    scale_t                  regime;
    logic [POSIT_ES-1:0]     exp_bits;
    acc_frac_t               frac;
    scale_t                  scale;
    logic                    is_zero;
    logic                    is_inf;

    assign abs_val = operand[POSIT_WIDTH-1] ? -operand : operand;
    assign body = abs_val[POSIT_WIDTH-2:0];

    // Length of the run of bits equal to the first regime bit
    always_comb
    begin
        run_len = 5'd1;
        run_end = 1'b0;
        for (int i = POSIT_WIDTH - 3; i >= 0; i--)
        begin
            if (!run_end)
            begin
                if (body[i] == body[POSIT_WIDTH-2])
                    run_len = run_len + 5'd1;
                else
                    run_end = 1'b1;
            end
        end
    end

    // Dropping the run and its terminator leaves exponent then fraction on top
    assign rem = body << (run_len + 5'd1);
    assign exp_bits = rem[POSIT_WIDTH-2 -: POSIT_ES];
    assign frac = {rem[FRAC_BITS-1:0], {(ACC_FRAC_WIDTH - FRAC_BITS){1'b0}}};

    assign regime = body[POSIT_WIDTH-2] ? scale_t'({3'b000, run_len}) - scale_t'(1)
                                        : -scale_t'({3'b000, run_len});
    assign scale = (regime <<< POSIT_ES) + scale_t'(exp_bits);

    assign is_zero = (operand == '0);
    assign is_inf = (operand == {1'b1, {(POSIT_WIDTH-1){1'b0}}});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dec_valid <= 1'b0;
            dec_clear <= 1'b0;
        end
        else
        begin
            dec_valid <= start;
            dec_clear <= clear;
        end
    end

    always_ff @(posedge clk)
    begin
        if (is_inf)
            dec_value <= RAW_INF_VALUE;
        else if (is_zero)
            dec_value <= RAW_ZERO_VALUE;
        else
            dec_value <= make_raw(operand[POSIT_WIDTH-1], scale, frac, 1'b0, 1'b0);
    end

endmodule

// ==== design/lead_one_detect.sv ====
/*
 * Leading zero count above the first one of the sum magnitude
 */
`timescale 1ns/1ps

module lead_one_detect
(
    input  logic [24:0] value,
    output logic [4:0]  position
);

    // All zero input reports the full width
    always_comb
    begin
        position = 5'd25;
        // Scan upward so the highest one wins
        for (int i = 0; i < 25; i++)
        begin
            if (value[i])
                position = 5'(24 - i);
        end
    end

endmodule

// ==== design/posit_accumulator.sv ====
/*
 * Four-stage raw value accumulator: sort, align, add, normalize,
 * with the running sum register loaded from the normalize stage
 */
`timescale 1ns/1ps

module posit_accumulator
    import posit_accum_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       dec_valid,
    input  logic       dec_clear,
    input  raw_value_t dec_value,
    output logic       acc_valid,
    output raw_value_t acc_value,
    output logic       acc_truncated
);

    // Magnitude with hidden bit, and the alignment field with guard bits
    localparam int MAG_WIDTH = ACC_FRAC_WIDTH + 1;
    localparam int ALIGN_WIDTH = MAG_WIDTH + ACC_FRAC_WIDTH;

    raw_value_t run_sum;
    raw_value_t base;

    logic       add_sgn, base_sgn;
    scale_t     add_scale, base_scale;
    acc_frac_t  add_frac, base_frac;
    logic       add_inf, base_inf;
    logic       add_zero, base_zero;
    logic       addend_larger;

    // Stage 1 sort
    logic                 s1_valid, s1_inf, s1_add, s1_sgn;
    scale_t               s1_scale;
    logic [MAG_WIDTH-1:0] s1_hi_mag, s1_lo_mag;
    logic [7:0]           s1_shift;

    // Stage 2 align
    logic                   s2_valid, s2_inf, s2_add, s2_sgn, s2_truncated;
    scale_t                 s2_scale;
    logic [MAG_WIDTH-1:0]   s2_hi_mag, s2_lo_mag;
    logic [ALIGN_WIDTH-1:0] lo_aligned;

    // Stage 3 add
    logic                 s3_valid, s3_inf, s3_sgn, s3_truncated;
    scale_t               s3_scale;
    logic [MAG_WIDTH:0]   s3_sum;

    // Stage 4 normalize
    logic [4:0]           lead_zeros;
    logic [MAG_WIDTH-1:0] norm_mag;
    raw_value_t           norm_value;

    assign base = dec_clear ? RAW_ZERO_VALUE : run_sum;

    assign add_sgn = dec_value[RAW_SGN_BIT];
    assign add_scale = dec_value[RAW_SCALE_LSB +: SCALE_WIDTH];
    assign add_frac = dec_value[RAW_FRAC_LSB +: ACC_FRAC_WIDTH];
    assign add_inf = dec_value[RAW_INF_BIT];
    assign add_zero = dec_value[RAW_ZERO_BIT];

    assign base_sgn = base[RAW_SGN_BIT];
    assign base_scale = base[RAW_SCALE_LSB +: SCALE_WIDTH];
    assign base_frac = base[RAW_FRAC_LSB +: ACC_FRAC_WIDTH];
    assign base_inf = base[RAW_INF_BIT];
    assign base_zero = base[RAW_ZERO_BIT];

    // A zero never wins and ties go to the addend
    assign addend_larger = base_zero
        | (~add_zero & ((add_scale > base_scale)
                        | ((add_scale == base_scale) & (add_frac >= base_frac))));

    always_ff @(posedge clk)
    begin
        s1_inf <= add_inf | base_inf;
        s1_add <= (add_sgn == base_sgn);
        if (addend_larger)
        begin
            s1_sgn <= add_sgn;
            s1_scale <= add_scale;
            s1_hi_mag <= {~add_zero, add_frac};
            s1_lo_mag <= {~base_zero, base_frac};
            s1_shift <= base_zero ? 8'd0 : 8'(add_scale - base_scale);
        end
        else
        begin
            s1_sgn <= base_sgn;
            s1_scale <= base_scale;
            s1_hi_mag <= {~base_zero, base_frac};
            s1_lo_mag <= {~add_zero, add_frac};
            s1_shift <= add_zero ? 8'd0 : 8'(base_scale - add_scale);
        end
    end

    assign lo_aligned = {s1_lo_mag, {ACC_FRAC_WIDTH{1'b0}}} >> s1_shift;

    always_ff @(posedge clk)
    begin
        s2_inf <= s1_inf;
        s2_add <= s1_add;
        s2_sgn <= s1_sgn;
        s2_scale <= s1_scale;
        s2_hi_mag <= s1_hi_mag;
        s2_lo_mag <= lo_aligned[ALIGN_WIDTH-1 -: MAG_WIDTH];
        s2_truncated <= |lo_aligned[ACC_FRAC_WIDTH-1:0];
    end

    // The larger magnitude is on the left so subtraction cannot go negative
    always_ff @(posedge clk)
    begin
        s3_inf <= s2_inf;
        s3_sgn <= s2_sgn;
        s3_scale <= s2_scale;
        s3_truncated <= s2_truncated;
        if (s2_add)
            s3_sum <= {1'b0, s2_hi_mag} + {1'b0, s2_lo_mag};
        else
            s3_sum <= {1'b0, s2_hi_mag} - {1'b0, s2_lo_mag};
    end

    lead_one_detect u_lead_one_detect
    (
        .value    (s3_sum[MAG_WIDTH-1:0]),
        .position (lead_zeros)
    );

    assign norm_mag = s3_sum[MAG_WIDTH-1:0] << lead_zeros;

    always_comb
    begin
        if (s3_inf)
            norm_value = RAW_INF_VALUE;
        else if (s3_sum[MAG_WIDTH])
            // Carry out moves the hidden bit up one place
            norm_value = make_raw(s3_sgn, s3_scale + scale_t'(1),
                                  s3_sum[MAG_WIDTH-1:1], 1'b0, 1'b0);
        else if (s3_sum == '0)
            norm_value = RAW_ZERO_VALUE;
        else
            norm_value = make_raw(s3_sgn, s3_scale - scale_t'({3'b000, lead_zeros}),
                                  norm_mag[ACC_FRAC_WIDTH-1:0], 1'b0, 1'b0);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            acc_valid <= 1'b0;
            acc_truncated <= 1'b0;
            run_sum <= RAW_ZERO_VALUE;
        end
        else
        begin
            s1_valid <= dec_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            acc_valid <= s3_valid;
            if (s3_valid)
            begin
                run_sum <= norm_value;
                acc_truncated <= s3_truncated;
            end
        end
    end

    assign acc_value = run_sum;

endmodule

// ==== design/posit_encode.sv ====
/*
 * Raw value to posit16 encoder with scale clamping and truncation,
 * registered together with the raw sum and the truncated flag
 */
`timescale 1ns/1ps

module posit_encode
    import posit_accum_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       acc_valid,
    input  raw_value_t acc_value,
    input  logic       acc_truncated,
    output logic       done,
    output raw_value_t sum_raw,
    output posit_t     sum_posit,
    output logic       truncated
);

    // Regime head, terminator, exponent and full fraction before shifting
    localparam int SRC_WIDTH = 2 + POSIT_ES + ACC_FRAC_WIDTH;

    logic                         sgn;
    scale_t                       scale;
    acc_frac_t                    frac;
    scale_t                       regime;
    logic [3:0]                   shamt;
    logic signed [SRC_WIDTH-1:0]  reg_src;
    logic signed [SRC_WIDTH-1:0]  reg_shifted;
    logic [POSIT_WIDTH-2:0]       body;
    posit_t                       magnitude;
    posit_t                       enc_posit;

    assign sgn = acc_value[RAW_SGN_BIT];
    assign scale = acc_value[RAW_SCALE_LSB +: SCALE_WIDTH];
    assign frac = acc_value[RAW_FRAC_LSB +: ACC_FRAC_WIDTH];

    assign regime = scale >>> POSIT_ES;

    // A positive regime is a run of ones ending in 0 and a negative one is zeros ending in 1
    assign reg_src = {~regime[SCALE_WIDTH-1], regime[SCALE_WIDTH-1],
                      scale[POSIT_ES-1:0], frac};
    assign shamt = regime[SCALE_WIDTH-1] ? ~regime[3:0] : regime[3:0];
    assign reg_shifted = reg_src >>> shamt;

    always_comb
    begin
        if (scale > MAX_SCALE)
            body = '1;
        else if (scale < -MAX_SCALE)
            body = {{(POSIT_WIDTH-2){1'b0}}, 1'b1};
        else
            body = reg_shifted[SRC_WIDTH-1 -: POSIT_WIDTH-1];
    end

    assign magnitude = {1'b0, body};

    always_comb
    begin
        if (acc_value[RAW_INF_BIT])
            enc_posit = {1'b1, {(POSIT_WIDTH-1){1'b0}}};
        else if (acc_value[RAW_ZERO_BIT])
            enc_posit = '0;
        else if (sgn)
            enc_posit = -magnitude;
        else
            enc_posit = magnitude;
    end

    // Results hold until the next accumulation completes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done <= 1'b0;
            truncated <= 1'b0;
            sum_raw <= RAW_ZERO_VALUE;
            sum_posit <= '0;
        end
        else
        begin
            done <= acc_valid;
            if (acc_valid)
            begin
                truncated <= acc_truncated;
                sum_raw <= acc_value;
                sum_posit <= enc_posit;
            end
        end
    end

endmodule

// ==== design/posit_accum_top.sv ====
/*
 * Posit16 accumulator top: decode, accumulate and encode stages
 */
`timescale 1ns/1ps

module posit_accum_top
    import posit_accum_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       clear,
    input  posit_t     operand,
    output logic       done,
    output raw_value_t sum_raw,
    output posit_t     sum_posit,
    output logic       truncated
);

    logic       dec_valid;
    logic       dec_clear;
    raw_value_t dec_value;

    logic       acc_valid;
    raw_value_t acc_value;
    logic       acc_truncated;

    posit_decode u_decode
    (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .clear     (clear),
        .operand   (operand),
        .dec_valid (dec_valid),
        .dec_clear (dec_clear),
        .dec_value (dec_value)
    );

    posit_accumulator u_accumulator
    (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .dec_clear     (dec_clear),
        .dec_value     (dec_value),
        .acc_valid     (acc_valid),
        .acc_value     (acc_value),
        .acc_truncated (acc_truncated)
    );

    posit_encode u_encode
    (
        .clk           (clk),
        .rst           (rst),
        .acc_valid     (acc_valid),
        .acc_value     (acc_value),
        .acc_truncated (acc_truncated),
        .done          (done),
        .sum_raw       (sum_raw),
        .sum_posit     (sum_posit),
        .truncated     (truncated)
    );

endmodule

// ==== tb/posit_accum_ref.svh ====
/*
 * Reference model of the posit16 (es = 2) accumulator: decode,
 * raw accumulate with alignment guard bits, and truncating encode
 */
`ifndef POSIT_ACCUM_REF_SVH
`define POSIT_ACCUM_REF_SVH

// Special raw values carry only their flag bit
localparam raw_value_t REF_ZERO = 35'd1;
localparam raw_value_t REF_INF = 35'd2;

function automatic raw_value_t ref_decode(input posit_t p);
    posit_t      mag;
    logic [14:0] bits;
    logic        first;
    int          n;
    int          regime;
    int          e;
    if (p == 16'h0000)
        return REF_ZERO;
    if (p == 16'h8000)
        return REF_INF;
    mag = p[15] ? (~p + 16'd1) : p;
    bits = mag[14:0];
    first = bits[14];
    n = 0;
    while (n < 15 && bits[14 - n] == first)
        n++;
    regime = first ? n - 1 : -n;
    // Exponent and fraction follow the regime terminator
    bits = bits << (n + 1);
    e = bits[14:13];
    return {p[15], 8'(regime * 4 + e), bits[12:0], 11'd0, 2'b00};
endfunction

function automatic raw_value_t ref_accumulate(
    input  raw_value_t sum,
    input  raw_value_t addend,
    output logic       trunc
);
    int          s_scale;
    int          a_scale;
    int          hi_scale;
    int          shift;
    int          lz;
    logic        a_wins;
    logic        hi_sign;
    logic [24:0] hi;
    logic [24:0] lo;
    logic [48:0] wide;
    logic [25:0] res;
    s_scale = $signed(sum[33:26]);
    a_scale = $signed(addend[33:26]);
    // Addend wins a tie and a zero sum always loses
    a_wins = sum[0] || (!addend[0] && (a_scale > s_scale
             || (a_scale == s_scale && addend[25:2] >= sum[25:2])));
    if (a_wins)
    begin
        hi = {~addend[0], addend[25:2]};
        lo = {~sum[0], sum[25:2]};
        hi_scale = a_scale;
        hi_sign = addend[34];
        shift = sum[0] ? 0 : a_scale - s_scale;
    end
    else
    begin
        hi = {~sum[0], sum[25:2]};
        lo = {~addend[0], addend[25:2]};
        hi_scale = s_scale;
        hi_sign = sum[34];
        shift = addend[0] ? 0 : s_scale - a_scale;
    end
    wide = {lo, 24'd0} >> shift;
    trunc = |wide[23:0];
    if (addend[34] == sum[34])
        res = {1'b0, hi} + {1'b0, wide[48:24]};
    else
        res = {1'b0, hi} - {1'b0, wide[48:24]};
    if (addend[1] || sum[1])
        return REF_INF;
    if (res[25])
        return {hi_sign, 8'(hi_scale + 1), res[24:1], 2'b00};
    if (res == 26'd0)
        return REF_ZERO;
    lz = 0;
    while (!res[24])
    begin
        res = res << 1;
        lz++;
    end
    return {hi_sign, 8'(hi_scale - lz), res[23:0], 2'b00};
endfunction

function automatic posit_t ref_encode(input raw_value_t v);
    int          sc;
    int          k;
    int          len;
    logic [63:0] rb;
    logic [63:0] stream;
    logic [14:0] body;
    posit_t      mag;
    if (v[1])
        return 16'h8000;
    if (v[0])
        return 16'h0000;
    sc = $signed(v[33:26]);
    if (sc > 56)
        body = 15'h7fff;
    else if (sc < -56)
        body = 15'h0001;
    else
    begin
        k = sc >>> 2;
        // Regime run and its terminator
        if (k >= 0)
        begin
            len = k + 2;
            rb = ((64'd1 << (k + 1)) - 64'd1) << 1;
        end
        else
        begin
            len = 1 - k;
            rb = 64'd1;
        end
        stream = (rb << 26) | (64'(sc - 4 * k) << 24) | 64'(v[25:2]);
        body = 15'(stream >> (len + 11));
    end
    mag = {1'b0, body};
    return v[34] ? -mag : mag;
endfunction

`endif

// ==== tb/posit_accum_tb.sv ====
/*
 * Posit16 accumulator testbench: clock and reset, directed and random
 * operand sequences, result checking against the reference model
 */
`timescale 1ns/1ps

module posit_accum_tb
    import posit_accum_pkg::*;
();

    localparam int CLEAR_OPS = 30;
    localparam int SEQ_COUNT = 3;
    localparam int SEQ_LEN = 20;
    localparam int DIRECTED_OPS = 19;
    localparam int N_OPS = CLEAR_OPS + SEQ_COUNT * SEQ_LEN + DIRECTED_OPS;
    // Eight cycles of 8 ns per operation plus reset and drain time
    localparam int WATCHDOG_NS = N_OPS * 8 * 8 + 2000;

    logic       clk;
    logic       rst;
    logic       start;
    logic       clear;
    posit_t     operand;
    logic       done;
    raw_value_t sum_raw;
    posit_t     sum_posit;
    logic       truncated;

    integer     seed = 32'ha3d2_ff70;
    int         errors = 0;
    int         issued = 0;
    int         checked = 0;
    posit_t     op_q[$];
    logic       clr_q[$];
    posit_t     cur_op;
    logic       cur_clr;
    raw_value_t model_sum;
    posit_t     model_posit;
    logic       model_trunc;

`include "posit_accum_ref.svh"

    posit_accum_top DUT
    (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .clear     (clear),
        .operand   (operand),
        .done      (done),
        .sum_raw   (sum_raw),
        .sum_posit (sum_posit),
        .truncated (truncated)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Issue one operation and wait for its done pulse
    task automatic run_op(input posit_t op, input logic clr);
        int cycles;
        op_q.push_back(op);
        clr_q.push_back(clr);
        issued++;
        @(negedge clk);
        start = 1'b1;
        clear = clr;
        operand = op;
        @(negedge clk);
        start = 1'b0;
        clear = 1'b0;
        cycles = 1;
        while (!done && cycles < 20)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("done did not rise within 20 cycles of the start for operand %h", op);
            errors++;
        end
        else if (cycles != 6)
        begin
            $display("[ERROR] %0t ns: done rose %0d cycles after start, expected 6",
                     $time, cycles);
            errors++;
        end
    endtask

    task automatic expect_posit(input posit_t want, input string what);
        if (sum_posit !== want)
        begin
            $display("[ERROR] %0t ns: %s gave %h, expected %h", $time, what, sum_posit, want);
            errors++;
        end
    endtask

    // Result comparison at every done
    always @(negedge clk)
    begin
        if (!rst && done === 1'b1)
        begin
            if (op_q.size() == 0)
            begin
                $display("done rose with no operation pending");
                errors++;
            end
            else
            begin
                cur_op = op_q.pop_front();
                cur_clr = clr_q.pop_front();
                model_sum = ref_accumulate(cur_clr ? REF_ZERO : model_sum,
                                           ref_decode(cur_op), model_trunc);
                model_posit = ref_encode(model_sum);
                checked++;
                if (sum_raw !== model_sum)
                begin
                    $display("[ERROR] %0t ns: sum_raw %h, expected %h after operand %h",
                             $time, sum_raw, model_sum, cur_op);
                    errors++;
                end
                if (sum_posit !== model_posit)
                begin
                    $display("[ERROR] %0t ns: sum_posit %h, expected %h after operand %h",
                             $time, sum_posit, model_posit, cur_op);
                    errors++;
                end
                if (truncated !== model_trunc)
                begin
                    $display("[ERROR] %0t ns: truncated %b, expected %b after operand %h",
                             $time, truncated, model_trunc, cur_op);
                    errors++;
                end
                if (cur_clr && sum_posit !== cur_op)
                begin
                    $display("[ERROR] %0t ns: cleared sum %h does not match operand %h",
                             $time, sum_posit, cur_op);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        posit_t x;
        rst = 1'b1;
        start = 1'b0;
        clear = 1'b0;
        operand = '0;
        model_sum = REF_ZERO;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (done !== 1'b0 || truncated !== 1'b0 || sum_raw !== REF_ZERO
            || sum_posit !== 16'h0000)
        begin
            $display("[ERROR] %0t ns: after reset done %b truncated %b sum_raw %h sum_posit %h",
                     $time, done, truncated, sum_raw, sum_posit);
            errors++;
        end

        for (int i = 0; i < CLEAR_OPS; i++)
            run_op(posit_t'($random(seed)), 1'b1);

        // Random running sums each opened with clear
        for (int s = 0; s < SEQ_COUNT; s++)
            for (int i = 0; i < SEQ_LEN; i++)
                run_op(posit_t'($random(seed)), i == 0);

        // Cancellation
        for (int i = 0; i < 3; i++)
        begin
            x = posit_t'($random(seed));
            if (x == 16'h8000)
                x = 16'h4000;
            run_op(x, 1'b1);
            run_op(-x, 1'b0);
            expect_posit(16'h0000, "x plus -x");
            if (sum_raw !== REF_ZERO)
            begin
                $display("[ERROR] %0t ns: x plus -x left sum_raw %h", $time, sum_raw);
                errors++;
            end
        end

        // NaR holds until the next clear
        run_op(16'h8000, 1'b1);
        for (int i = 0; i < 3; i++)
        begin
            run_op(posit_t'($random(seed)), 1'b0);
            expect_posit(16'h8000, "sum after NaR");
        end
        run_op(16'h3000, 1'b1);
        expect_posit(16'h3000, "clear after NaR");

        run_op(16'h7fff, 1'b1);
        run_op(16'h7fff, 1'b0);
        expect_posit(16'h7fff, "maxpos plus maxpos");
        run_op(16'h8001, 1'b1);
        run_op(16'h8001, 1'b0);
        expect_posit(16'h8001, "-maxpos plus -maxpos");

        run_op(16'h0001, 1'b1);
        run_op(16'h0001, 1'b0);
        expect_posit(16'h0001, "minpos plus minpos");
        run_op(16'hffff, 1'b1);
        run_op(16'hffff, 1'b0);
        expect_posit(16'hffff, "-minpos plus -minpos");

        repeat (4) @(negedge clk);
        if (checked != issued)
        begin
            $display("Only %0d of %0d results were checked", checked, issued);
            errors++;
        end
        $display("Checked %0d results with %0d errors", checked, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== posit_accum.f ====
+incdir+tb
design/posit_accum_pkg.sv
design/posit_decode.sv
design/lead_one_detect.sv
design/posit_accumulator.sv
design/posit_encode.sv
design/posit_accum_top.sv
tb/posit_accum_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the posit accumulator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module posit_accum_tb \
    -f posit_accum.f -o sim_posit_accum || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_posit_accum)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }
